// File: hw/gray_pkg.sv
// Gray converter shared definitions
package gray_pkg;

    // Register map
    // Byte offsets within the slave window
    localparam logic [31:0] pixel_off = 32'h0000_0000;
    localparam logic [31:0] gray_off  = 32'h0000_0004;

    // AXI response codes
    // EXOKAY and DECERR are never returned by this slave
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

    // Transaction opcodes produced by the channel decode
    typedef enum logic [2:0] {
        // Idle cycle, no transaction this cycle
        op_none,
        // Write to the pixel register
        op_write_pixel,
        // Write to any other offset
        op_write_bad,
        // Read of the pixel register
        op_read_pixel,
        // Read of the gray result
        op_read_gray,
        // Read of an unmapped offset
        op_read_bad
    } gray_op_t;

    // Write request, valid for one cycle when op is not op_none
    typedef struct packed {
        // Decoded write opcode
        gray_op_t    op;
        // Captured write data word
        logic [31:0] data;
        // Captured byte strobes
        logic [3:0]  strb;
    } wr_req_t;

    // Register file contents seen by the read path
    typedef struct packed {
        // Stored RGB888 pixel
        // R in bits 23:16, G in 15:8, B in 7:0
        logic [23:0] pixel;
        // Luma result of the stored pixel
        logic [7:0]  gray;
    } gray_regs_t;

endpackage

// File: hw/axi_lite_decode.sv
// AXI4-Lite channel decode
module axi_lite_decode #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    // Write address channel
    input  logic [ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    // Write data channel
    input  logic [31:0]           s_axi_wdata,
    input  logic [3:0]            s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,
    // Read address channel
    input  logic [ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    // Response handshakes from the result block
    input  logic                  wr_done,
    input  logic                  rd_done,
    // Decoded transactions
    output gray_pkg::wr_req_t     wr_req,
    output gray_pkg::gray_op_t    rd_op
);
    import gray_pkg::*;

    // Word address width, byte lane bits dropped
    localparam int WORD_BITS = ADDR_WIDTH - 2;
    localparam logic [WORD_BITS-1:0] PIXEL_WORD = pixel_off[ADDR_WIDTH-1:2];
    localparam logic [WORD_BITS-1:0] GRAY_WORD  = gray_off[ADDR_WIDTH-1:2];

    // Channel handshakes
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    // Captured flags, one per channel
    logic aw_held;
    logic w_held;
    logic ar_held;
    // Both write halves present
    logic wr_fire;
    // Captured payload
    logic [WORD_BITS-1:0] aw_word;
    logic [WORD_BITS-1:0] ar_word;
    logic [31:0]          w_data;
    logic [3:0]           w_strb;

    assign aw_hs   = s_axi_awvalid & s_axi_awready;
    assign w_hs    = s_axi_wvalid & s_axi_wready;
    assign ar_hs   = s_axi_arvalid & s_axi_arready;
    assign wr_fire = aw_held & w_held;

    // Readies
    // Each drops on its own handshake and returns with the response handshake
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            s_axi_awready <= 1'b1;
            s_axi_wready  <= 1'b1;
            s_axi_arready <= 1'b1;
        end else begin
            if (aw_hs) begin
                s_axi_awready <= 1'b0;
            end else if (wr_done) begin
                s_axi_awready <= 1'b1;
            end
            if (w_hs) begin
                s_axi_wready <= 1'b0;
            end else if (wr_done) begin
                s_axi_wready <= 1'b1;
            end
            if (ar_hs) begin
                s_axi_arready <= 1'b0;
            end else if (rd_done) begin
                s_axi_arready <= 1'b1;
            end
        end
    end

    // Held flags
    // Cleared on the strobe cycle so each op lasts exactly one cycle
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            ar_held <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_held <= 1'b1;
            end else if (wr_fire) begin
                aw_held <= 1'b0;
            end
            if (w_hs) begin
                w_held <= 1'b1;
            end else if (wr_fire) begin
                w_held <= 1'b0;
            end
            // Read op stays up for a single cycle
            ar_held <= ar_hs;
        end
    end

    // Payload capture
    always_ff @(posedge s_axi_aclk) begin
        if (aw_hs) begin
            aw_word <= s_axi_awaddr[ADDR_WIDTH-1:2];
        end
        if (w_hs) begin
            w_data <= s_axi_wdata;
            w_strb <= s_axi_wstrb;
        end
        if (ar_hs) begin
            ar_word <= s_axi_araddr[ADDR_WIDTH-1:2];
        end
    end

    // Write classification
    // Only the pixel word is writable
    always_comb begin
        wr_req.op   = op_none;
        wr_req.data = w_data;
        wr_req.strb = w_strb;
        if (wr_fire) begin
            wr_req.op = (aw_word == PIXEL_WORD) ? op_write_pixel : op_write_bad;
        end
    end

    // Read classification
    always_comb begin
        rd_op = op_none;
        if (ar_held) begin
            if (ar_word == PIXEL_WORD) begin
                rd_op = op_read_pixel;
            end else if (ar_word == GRAY_WORD) begin
                rd_op = op_read_gray;
            end else begin
                rd_op = op_read_bad;
            end
        end
    end

endmodule

// File: hw/gray_execute.sv
// Pixel register and gray datapath
module gray_execute #(
    parameter logic [7:0] R_COEFF = 8'd77,
    parameter logic [7:0] G_COEFF = 8'd150,
    parameter logic [7:0] B_COEFF = 8'd29
) (
    input  logic                 s_axi_aclk,
    input  logic                 s_axi_aresetn,
    // One-cycle write strobe from the decode
    input  gray_pkg::wr_req_t    wr_req,
    // Stored pixel and its gray value
    output gray_pkg::gray_regs_t regs
);
    import gray_pkg::*;

    // Pixel write this cycle
    logic        pixel_wr;
    // Pixel after strobe merge
    logic [23:0] pixel_next;
    logic [23:0] pixel_q;
    // Gray load pending, one cycle behind the pixel update
    logic        gray_pend;
    logic [7:0]  gray_q;
    // Weighted channels
    logic [15:0] r_prod;
    logic [15:0] g_prod;
    logic [15:0] b_prod;
    // Room for any 8-bit weights
    logic [17:0] luma_sum;

    assign pixel_wr = (wr_req.op == op_write_pixel);

    // Byte merge under strobes
    // Strobe bit 3 has no byte to land in
    always_comb begin
        pixel_next = pixel_q;
        for (int i = 0; i < 3; i++) begin
            if (wr_req.strb[i]) begin
                pixel_next[8*i +: 8] = wr_req.data[8*i +: 8];
            end
        end
    end

    // Pixel register
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            pixel_q <= 24'h0;
        end else if (pixel_wr) begin
            pixel_q <= pixel_next;
        end
    end

    // Products taken from the updated pixel register
    assign r_prod   = R_COEFF * pixel_q[23:16];
    assign g_prod   = G_COEFF * pixel_q[15:8];
    assign b_prod   = B_COEFF * pixel_q[7:0];
    assign luma_sum = r_prod + g_prod + b_prod;

    // Gray register
    // Loaded on the edge after the pixel write, shift by 8 and truncate
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            gray_pend <= 1'b0;
            gray_q    <= 8'h0;
        end else begin
            gray_pend <= pixel_wr;
            if (gray_pend) begin
                gray_q <= luma_sum[15:8];
            end
        end
    end

    // Register view for the read path
    assign regs.pixel = pixel_q;
    assign regs.gray  = gray_q;

endmodule

// File: hw/axi_lite_result.sv
// AXI4-Lite response generation
module axi_lite_result (
    input  logic                 s_axi_aclk,
    input  logic                 s_axi_aresetn,
    // Decoded transactions
    input  gray_pkg::wr_req_t    wr_req,
    input  gray_pkg::gray_op_t   rd_op,
    // Register contents
    input  gray_pkg::gray_regs_t regs,
    // Write response channel
    output logic [1:0]           s_axi_bresp,
    output logic                 s_axi_bvalid,
    input  logic                 s_axi_bready,
    // Read data channel
    output logic [31:0]          s_axi_rdata,
    output logic [1:0]           s_axi_rresp,
    output logic                 s_axi_rvalid,
    input  logic                 s_axi_rready,
    // Handshake pulses back to the decode
    output logic                 wr_done,
    output logic                 rd_done
);
    import gray_pkg::*;

    // Write strobe this cycle
    logic        wr_strobe;
    // Read strobe this cycle
    logic        rd_strobe;
    // Response for the current write
    axi_resp_t   wr_resp;
    // Data and response for the current read
    axi_resp_t   rd_resp;
    logic [31:0] rd_data;
    // Held response codes
    axi_resp_t   bresp_q;
    axi_resp_t   rresp_q;

    assign wr_strobe = (wr_req.op != op_none);
    assign rd_strobe = (rd_op != op_none);
    assign wr_resp   = (wr_req.op == op_write_pixel) ? resp_okay : resp_slverr;

    // Read mux, zero-extended registers
    always_comb begin
        rd_data = 32'h0;
        rd_resp = resp_okay;
        case (rd_op)
            op_read_pixel: rd_data = {8'h0, regs.pixel};
            op_read_gray:  rd_data = {24'h0, regs.gray};
            default:       rd_resp = resp_slverr;
        endcase
    end

    // Write response
    // Held until bready, next strobe cannot come before wr_done
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            s_axi_bvalid <= 1'b0;
            bresp_q      <= resp_okay;
        end else if (wr_strobe) begin
            s_axi_bvalid <= 1'b1;
            bresp_q      <= wr_resp;
        end else if (wr_done) begin
            s_axi_bvalid <= 1'b0;
        end
    end

    // Read response valid and code
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            s_axi_rvalid <= 1'b0;
            rresp_q      <= resp_okay;
        end else if (rd_strobe) begin
            s_axi_rvalid <= 1'b1;
            rresp_q      <= rd_resp;
        end else if (rd_done) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    // Read data, stable while rvalid is up
    always_ff @(posedge s_axi_aclk) begin
        if (rd_strobe) begin
            s_axi_rdata <= rd_data;
        end
    end

    assign s_axi_bresp = bresp_q;
    assign s_axi_rresp = rresp_q;

    // Done pulses mark the handshake cycle
    assign wr_done = s_axi_bvalid & s_axi_bready;
    assign rd_done = s_axi_rvalid & s_axi_rready;

endmodule

// File: hw/rgb_to_gray_top.sv
// RGB to gray AXI4-Lite slave
module rgb_to_gray_top #(
    parameter int         ADDR_WIDTH = 32,
    parameter logic [7:0] R_COEFF    = 8'd77,
    parameter logic [7:0] G_COEFF    = 8'd150,
    parameter logic [7:0] B_COEFF    = 8'd29
) (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    // Write address channel
    input  logic [ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    // Write data channel
    input  logic [31:0]           s_axi_wdata,
    input  logic [3:0]            s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,
    // Write response channel
    output logic [1:0]            s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,
    // Read address channel
    input  logic [ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    // Read data channel
    output logic [31:0]           s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready
);
    import gray_pkg::*;

    // Decode to datapath and response
    wr_req_t    wr_req;
    gray_op_t   rd_op;
    // Datapath to read mux
    gray_regs_t regs;
    // Response handshakes back to decode
    logic       wr_done;
    logic       rd_done;

    axi_lite_decode #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_decode (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .wr_done       (wr_done),
        .rd_done       (rd_done),
        .wr_req        (wr_req),
        .rd_op         (rd_op)
    );

    gray_execute #(
        .R_COEFF (R_COEFF),
        .G_COEFF (G_COEFF),
        .B_COEFF (B_COEFF)
    ) u_execute (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .wr_req        (wr_req),
        .regs          (regs)
    );

    axi_lite_result u_result (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .wr_req        (wr_req),
        .rd_op         (rd_op),
        .regs          (regs),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wr_done       (wr_done),
        .rd_done       (rd_done)
    );

endmodule

// File: test/tb_rgb_to_gray.sv
// RGB to gray testbench
module tb_rgb_to_gray;
    import gray_pkg::*;

    // Cycles any single wait may take
    localparam int    TIMEOUT   = 200;
    localparam string DATA_FILE = "test/rgb_to_gray_testdata.txt";

    logic        s_axi_aclk = 1'b0;
    logic        s_axi_aresetn;
    logic [31:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [31:0] s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;

    // Run state
    logic [31:0] lfsr_state;
    int          error_count;
    bit          hung;

    rgb_to_gray_top u_rgb_to_gray_top (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

    always #5 s_axi_aclk = ~s_axi_aclk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] val;
        logic       bit_out;
        val = 8'h0;
        for (int i = 0; i < n; i++) begin
            bit_out    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (bit_out) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            val = {val[6:0], bit_out};
        end
        return val;
    endfunction

    task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s response %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: read data %h, expected %h", $time, got, exp);
            error_count++;
        end
    endtask

    // Single control level such as a ready or a valid
    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        error_count++;
        hung = 1'b1;
    endtask

    // One write with random AW/W order and bready delay
    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input axi_resp_t exp_resp);
        int order;
        int cnt;
        int delay;
        bit aw_done;
        bit w_done;
        bit aw_hit;
        bit w_hit;
        // 0 is AW first, 1 is W first, 2 is both together
        order   = rand_bits(2) % 3;
        delay   = rand_bits(3);
        aw_done = 1'b0;
        w_done  = 1'b0;
        cnt     = 0;
        @(posedge s_axi_aclk);
        s_axi_awaddr  <= addr;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= strb;
        s_axi_awvalid <= (order != 1);
        s_axi_wvalid  <= (order != 0);
        while (!(aw_done && w_done)) begin
            @(negedge s_axi_aclk);
            aw_hit = s_axi_awvalid && s_axi_awready;
            w_hit  = s_axi_wvalid && s_axi_wready;
            cnt++;
            if (cnt > TIMEOUT) begin
                report_timeout("write address and data handshakes");
                return;
            end
            @(posedge s_axi_aclk);
            if (aw_hit) begin
                aw_done = 1'b1;
                s_axi_awvalid <= 1'b0;
            end
            if (w_hit) begin
                w_done = 1'b1;
                s_axi_wvalid <= 1'b0;
            end
            // Second channel starts once the first has transferred
            if (aw_done && !w_done && order == 0) begin
                s_axi_wvalid <= 1'b1;
            end
            if (w_done && !aw_done && order == 1) begin
                s_axi_awvalid <= 1'b1;
            end
        end
        cnt = 0;
        do begin
            @(negedge s_axi_aclk);
            cnt++;
            check_flag(s_axi_awready, 1'b0, "awready before write response");
            check_flag(s_axi_wready, 1'b0, "wready before write response");
        end while (!s_axi_bvalid && cnt <= TIMEOUT);
        if (!s_axi_bvalid) begin
            report_timeout("write response valid");
            return;
        end
        // Bvalid and readies hold through back-pressure
        repeat (delay) begin
            @(negedge s_axi_aclk);
            check_flag(s_axi_bvalid, 1'b1, "bvalid under back-pressure");
            check_flag(s_axi_awready, 1'b0, "awready before write response");
            check_flag(s_axi_wready, 1'b0, "wready before write response");
        end
        check_resp(axi_resp_t'(s_axi_bresp), exp_resp, "write");
        @(posedge s_axi_aclk);
        s_axi_bready <= 1'b1;
        @(posedge s_axi_aclk);
        s_axi_bready <= 1'b0;
        // Response drops and the readies return after the handshake
        @(negedge s_axi_aclk);
        check_flag(s_axi_bvalid, 1'b0, "bvalid after write response");
        check_flag(s_axi_awready, 1'b1, "awready after write response");
        check_flag(s_axi_wready, 1'b1, "wready after write response");
    endtask

    // One read with random rready delay
    task automatic do_read(input logic [31:0] addr, input axi_resp_t exp_resp,
                           input logic [31:0] exp_data);
        int cnt;
        int delay;
        delay = rand_bits(3);
        @(posedge s_axi_aclk);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        cnt = 0;
        do begin
            @(negedge s_axi_aclk);
            cnt++;
        end while (!s_axi_arready && cnt <= TIMEOUT);
        if (!s_axi_arready) begin
            report_timeout("read address ready");
            return;
        end
        @(posedge s_axi_aclk);
        s_axi_arvalid <= 1'b0;
        cnt = 0;
        do begin
            @(negedge s_axi_aclk);
            cnt++;
            check_flag(s_axi_arready, 1'b0, "arready before read response");
        end while (!s_axi_rvalid && cnt <= TIMEOUT);
        if (!s_axi_rvalid) begin
            report_timeout("read data valid");
            return;
        end
        repeat (delay) begin
            @(negedge s_axi_aclk);
            check_flag(s_axi_rvalid, 1'b1, "rvalid under back-pressure");
            check_flag(s_axi_arready, 1'b0, "arready before read response");
        end
        check_rdata(s_axi_rdata, exp_data);
        check_resp(axi_resp_t'(s_axi_rresp), exp_resp, "read");
        @(posedge s_axi_aclk);
        s_axi_rready <= 1'b1;
        @(posedge s_axi_aclk);
        s_axi_rready <= 1'b0;
        // Read data drops and arready returns after the handshake
        @(negedge s_axi_aclk);
        check_flag(s_axi_rvalid, 1'b0, "rvalid after read response");
        check_flag(s_axi_arready, 1'b1, "arready after read response");
    endtask

    initial begin
        int          fd;
        int          n;
        int          test_no;
        int          pass_count;
        int          fail_count;
        int          errs_before;
        string       line;
        logic [3:0]  kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  resp;
        logic [31:0] rdata;
        lfsr_state    = 32'h9aae_df91;
        error_count   = 0;
        hung          = 1'b0;
        test_no       = 0;
        pass_count    = 0;
        fail_count    = 0;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = 32'h0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = 32'h0;
        s_axi_wstrb   = 4'h0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = 32'h0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        repeat (2) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;
        // Idle state straight out of reset
        @(negedge s_axi_aclk);
        check_flag(s_axi_awready, 1'b1, "awready after reset");
        check_flag(s_axi_wready, 1'b1, "wready after reset");
        check_flag(s_axi_arready, 1'b1, "arready after reset");
        check_flag(s_axi_bvalid, 1'b0, "bvalid after reset");
        check_flag(s_axi_rvalid, 1'b0, "rvalid after reset");
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open the data file %s", DATA_FILE);
            error_count++;
        end else begin
            // Comment and blank lines fail the scan and are skipped
            while (!hung && $fgets(line, fd) > 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h", kind, addr, data, strb, resp, rdata);
                if (n == 6) begin
                    test_no++;
                    errs_before = error_count;
                    repeat (rand_bits(2)) @(posedge s_axi_aclk);
                    if (kind == 4'h0) begin
                        do_write(addr, data, strb, axi_resp_t'(resp));
                    end else begin
                        do_read(addr, axi_resp_t'(resp), rdata);
                    end
                    if (error_count == errs_before) begin
                        pass_count++;
                        $display("test %0d: %s at %h ok", test_no,
                                 (kind == 4'h0) ? "write" : "read", addr);
                    end else begin
                        fail_count++;
                        $display("test %0d: %s at %h failed", test_no,
                                 (kind == 4'h0) ? "write" : "read", addr);
                    end
                end
            end
            $fclose(fd);
        end
        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count,
                 error_count);
        if (error_count == 0 && test_no > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: test/rgb_to_gray_testdata.txt
# kind (0 write, 1 read), address, write data, strobe, expected resp (0 okay, 2 slverr),
# expected read data; all columns hex, gray = (77 R + 150 G + 29 B) >> 8
1 00000000 00000000 0 0 00000000
1 00000004 00000000 0 0 00000000
0 00000000 00ffffff f 0 00000000
1 00000004 00000000 0 0 000000ff
1 00000000 00000000 0 0 00ffffff
0 00000000 00ff0000 f 0 00000000
1 00000004 00000000 0 0 0000004c
0 00000000 0000ff00 f 0 00000000
1 00000004 00000000 0 0 00000095
0 00000000 000000ff f 0 00000000
1 00000004 00000000 0 0 0000001c
0 00000000 00000000 f 0 00000000
1 00000004 00000000 0 0 00000000
0 00000000 0080c040 f 0 00000000
1 00000004 00000000 0 0 0000009e
0 00000000 de123456 f 0 00000000
1 00000000 00000000 0 0 00123456
1 00000004 00000000 0 0 0000002d
0 00000000 aabbccdd 2 0 00000000
1 00000000 00000000 0 0 0012cc56
1 00000004 00000000 0 0 00000086
0 00000000 ffffffff 8 0 00000000
1 00000000 00000000 0 0 0012cc56
1 00000004 00000000 0 0 00000086
0 00000000 9910ee20 5 0 00000000
1 00000000 00000000 0 0 0010cc20
1 00000004 00000000 0 0 0000007f
0 00000004 ffffffff f 2 00000000
0 00000008 ffffffff f 2 00000000
0 00000100 00000000 f 2 00000000
1 00000000 00000000 0 0 0010cc20
1 00000004 00000000 0 0 0000007f
1 00000008 00000000 0 2 00000000
1 0000000c 00000000 0 2 00000000
1 fffffffc 00000000 0 2 00000000

// File: compile.f
hw/gray_pkg.sv
hw/axi_lite_decode.sv
hw/gray_execute.sv
hw/axi_lite_result.sv
hw/rgb_to_gray_top.sv
test/tb_rgb_to_gray.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the RGB to gray simulation with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb
LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f compile.f \
    --top-module tb_rgb_to_gray \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -qx "SIMULATION PASSED" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
